// File: src/periph_cfg.svh
/*
 * Widths, slot numbers and register offsets of the peripheral hub
 */

`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// Bus and pin widths
`define PERIPH_ADDR_W       11
`define PERIPH_DATA_W       32
`define PERIPH_PIN_W        8
`define PERIPH_SLOT_W       4

`define PERIPH_SIMPLE_BIT   10      // Set for the 16-byte simple slots

// Live slots
`define PERIPH_GPIO_SLOT    1       // User slot
`define PERIPH_PWM_SLOT     5       // Simple slot

// GPIO register offsets within the user slot
`define GPIO_OUT_OFS        6'h00
`define GPIO_IN_OFS         6'h04
`define GPIO_AUDIO_OFS      6'h10

`define PWM_DUTY_OFS        4'h0

`endif

// File: src/periph_pkg.sv
/*
 * Shared types: core access code and pin function select
 */

`include "periph_cfg.svh"

package periph_pkg;

    // Request code from the core, all ones when idle
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10,
        ACC_NONE = 2'b11
    } access_t;

    // Output source of one pin
    typedef struct packed {
        logic                          simple; // Simple slot rather than user slot
        logic [`PERIPH_SLOT_W-1:0]     slot;
    } func_sel_t;

endpackage

// File: src/periph_decode.sv
/*
 * Slot decode: write strobes for the live slots and read data select
 */

`include "periph_cfg.svh"

module periph_decode (
    input  logic [`PERIPH_ADDR_W-1:0] i_addr,
    input  periph_pkg::access_t       i_data_write_n,
    input  logic [`PERIPH_DATA_W-1:0] i_gpio_rdata,
    input  logic [7:0]                i_pwm_rdata,
    output logic                      o_gpio_wr,
    output logic                      o_pwm_wr,
    output logic [`PERIPH_DATA_W-1:0] o_rdata
);

    localparam int USER_LSB   = `PERIPH_SIMPLE_BIT - `PERIPH_SLOT_W;  // 64-byte user slots
    localparam int SIMPLE_LSB = 4;                                   // 16-byte simple slots

    localparam logic [`PERIPH_SLOT_W-1:0] GPIO_SLOT = `PERIPH_GPIO_SLOT;
    localparam logic [`PERIPH_SLOT_W-1:0] PWM_SLOT  = `PERIPH_PWM_SLOT;

    logic                      is_simple;
    logic [`PERIPH_SLOT_W-1:0] user_slot;
    logic [`PERIPH_SLOT_W-1:0] simple_slot;
    logic                      wr_req;
    logic                      gpio_hit;
    logic                      pwm_hit;

    assign is_simple   = i_addr[`PERIPH_SIMPLE_BIT];
    assign user_slot   = i_addr[USER_LSB +: `PERIPH_SLOT_W];
    assign simple_slot = i_addr[SIMPLE_LSB +: `PERIPH_SLOT_W];

    assign wr_req   = i_data_write_n != periph_pkg::ACC_NONE;
    assign gpio_hit = !is_simple && (user_slot == GPIO_SLOT);
    assign pwm_hit  = is_simple && (simple_slot == PWM_SLOT);

    // One strobe per write, the core never holds a write
    assign o_gpio_wr = wr_req && gpio_hit;
    assign o_pwm_wr  = wr_req && pwm_hit;

    always_comb begin
        o_rdata = '0;                               // Empty slots read zero
        if (gpio_hit) begin
            o_rdata = i_gpio_rdata;
        end else if (pwm_hit) begin
            o_rdata[7:0] = i_pwm_rdata;             // Byte peripheral, zero-extended
        end
    end

endmodule

// File: src/read_data_hold.sv
/*
 * Registered read data held until read complete, plus ready generation
 */

`include "periph_cfg.svh"

module read_data_hold (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`PERIPH_DATA_W-1:0] i_rdata,
    input  periph_pkg::access_t       i_data_read_n,
    input  periph_pkg::access_t       i_data_write_n,
    input  logic                      i_data_read_complete,
    output logic [`PERIPH_DATA_W-1:0] o_data_out,
    output logic                      o_data_ready
);

    logic                      read_req;
    logic                      write_req;
    logic                      hold_q;     // A read value is waiting for the core
    logic                      ready_q;
    logic [`PERIPH_DATA_W-1:0] data_q;
    logic                      capture;

    assign read_req  = i_data_read_n != periph_pkg::ACC_NONE;
    assign write_req = i_data_write_n != periph_pkg::ACC_NONE;

    // First cycle of a request, nothing held yet
    assign capture = read_req && !hold_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                hold_q <= 1'b0;
            end
            if (capture) begin
                hold_q <= 1'b1;
            end
            ready_q <= read_req;                // Every slot answers at once
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= i_rdata;
        end
    end

    assign o_data_out = data_q;

    // Writes complete in the cycle they are issued
    assign o_data_ready = ready_q || write_req;

endmodule

// File: src/gpio_ctrl.sv
/*
 * GPIO block: output register, input readback, audio select
 * and per-pin function select registers
 */

`include "periph_cfg.svh"

module gpio_ctrl (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     i_wr,
    input  logic [5:0]                               i_offset,
    input  logic [7:0]                               i_wdata,
    input  logic [`PERIPH_PIN_W-1:0]                 i_ui_in,
    output logic [`PERIPH_DATA_W-1:0]                o_rdata,
    output logic [`PERIPH_PIN_W-1:0]                 o_gpio_out,
    output periph_pkg::func_sel_t [`PERIPH_PIN_W-1:0] o_func_sel,
    output logic                                     o_audio_select
);

    localparam int PIN_IDX_W = $clog2(`PERIPH_PIN_W);

    // Pins start on the GPIO output register
    localparam periph_pkg::func_sel_t GPIO_FUNC = '{
        simple: 1'b0,
        slot:   `PERIPH_SLOT_W'(`PERIPH_GPIO_SLOT)
    };

    logic [`PERIPH_PIN_W-1:0]                  gpio_out_q;
    logic [2:0]                                audio_sel_q;
    periph_pkg::func_sel_t [`PERIPH_PIN_W-1:0] func_sel_q;

    logic                 sel_hit;
    logic [PIN_IDX_W-1:0] sel_pin;

    // Function selects sit at 0x20 + 4 * pin
    assign sel_hit = i_offset[5] && (i_offset[1:0] == 2'b00);
    assign sel_pin = i_offset[2 +: PIN_IDX_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out_q  <= '0;
            audio_sel_q <= '0;
            func_sel_q  <= {`PERIPH_PIN_W{GPIO_FUNC}};
        end else if (i_wr) begin
            if (i_offset == `GPIO_OUT_OFS) begin
                gpio_out_q <= i_wdata;
            end
            if (i_offset == `GPIO_AUDIO_OFS) begin
                audio_sel_q <= i_wdata[2:0];
            end
            if (sel_hit) begin
                func_sel_q[sel_pin] <= periph_pkg::func_sel_t'(i_wdata[4:0]);
            end
        end
    end

    // Register readback, unmapped offsets give zero
    always_comb begin
        o_rdata = '0;
        if (i_offset == `GPIO_OUT_OFS) begin
            o_rdata[`PERIPH_PIN_W-1:0] = gpio_out_q;
        end else if (i_offset == `GPIO_IN_OFS) begin
            o_rdata[`PERIPH_PIN_W-1:0] = i_ui_in;
        end else if (i_offset == `GPIO_AUDIO_OFS) begin
            o_rdata[2:0] = audio_sel_q;
        end else if (sel_hit) begin
            o_rdata[4:0] = func_sel_q[sel_pin];
        end
    end

    assign o_gpio_out     = gpio_out_q;
    assign o_func_sel     = func_sel_q;
    assign o_audio_select = audio_sel_q[2];  // Top bit routes PWM audio out

endmodule

// File: src/pin_func_mux.sv
/*
 * Output pin multiplexer driven by the per-pin function selects
 */

`include "periph_cfg.svh"

module pin_func_mux (
    input  periph_pkg::func_sel_t [`PERIPH_PIN_W-1:0] i_func_sel,
    input  logic [`PERIPH_PIN_W-1:0]                 i_gpio_out,
    input  logic [`PERIPH_PIN_W-1:0]                 i_pwm_pins,
    output logic [`PERIPH_PIN_W-1:0]                 o_uo_out
);

    localparam logic [`PERIPH_SLOT_W-1:0] GPIO_SLOT = `PERIPH_GPIO_SLOT;
    localparam logic [`PERIPH_SLOT_W-1:0] PWM_SLOT  = `PERIPH_PWM_SLOT;

    // Pin i always takes bit i of its chosen source
    always_comb begin
        for (int i = 0; i < `PERIPH_PIN_W; i++) begin
            o_uo_out[i] = 1'b0;                 // Empty slots drive low
            if (!i_func_sel[i].simple && (i_func_sel[i].slot == GPIO_SLOT)) begin
                o_uo_out[i] = i_gpio_out[i];
            end else if (i_func_sel[i].simple && (i_func_sel[i].slot == PWM_SLOT)) begin
                o_uo_out[i] = i_pwm_pins[i];
            end
        end
    end

endmodule

// File: src/pwm_byte.sv
/*
 * Byte-interface PWM: duty register and free-running 8-bit counter
 */

`include "periph_cfg.svh"

module pwm_byte (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     i_wr,
    input  logic [3:0]               i_offset,
    input  logic [7:0]               i_wdata,
    output logic [7:0]               o_rdata,
    output logic [`PERIPH_PIN_W-1:0] o_pins
);

    logic [7:0] count_q;
    logic [7:0] duty_q;
    logic       pwm_q;
    logic       duty_sel;

    assign duty_sel = i_offset == `PWM_DUTY_OFS;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            duty_q <= '0;                       // Output stays low until programmed
        end else if (i_wr && duty_sel) begin
            duty_q <= i_wdata;
        end
    end

    // Period of 256 cycles, wraps on its own
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= '0;
            pwm_q   <= 1'b0;
        end else begin
            count_q <= count_q + 8'd1;
            pwm_q   <= count_q < duty_q;        // High for duty_q counts per period
        end
    end

    assign o_pins  = {`PERIPH_PIN_W{pwm_q}};
    assign o_rdata = duty_sel ? duty_q : 8'h00;

endmodule

// File: src/periph_hub.sv
/*
 * Peripheral hub top: decode, read hold, GPIO, pin mux and PWM
 */

`include "periph_cfg.svh"

module periph_hub (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`PERIPH_PIN_W-1:0]  i_ui_in,
    input  logic [`PERIPH_ADDR_W-1:0] i_addr,
    input  logic [`PERIPH_DATA_W-1:0] i_data,        // Only the low byte reaches the registers
    input  periph_pkg::access_t       i_data_write_n,
    input  periph_pkg::access_t       i_data_read_n,
    input  logic                      i_data_read_complete,
    output logic [`PERIPH_DATA_W-1:0] o_data_out,
    output logic                      o_data_ready,
    output logic [`PERIPH_PIN_W-1:0]  o_uo_out,
    output logic                      o_audio,
    output logic                      o_audio_select
);

    logic                                      gpio_wr;
    logic                                      pwm_wr;
    logic [`PERIPH_DATA_W-1:0]                 rdata;
    logic [`PERIPH_DATA_W-1:0]                 gpio_rdata;
    logic [7:0]                                pwm_rdata;
    logic [`PERIPH_PIN_W-1:0]                  gpio_out;
    logic [`PERIPH_PIN_W-1:0]                  pwm_pins;
    periph_pkg::func_sel_t [`PERIPH_PIN_W-1:0] func_sel;

    periph_decode i_decode (
        .i_addr         (i_addr),
        .i_data_write_n (i_data_write_n),
        .i_gpio_rdata   (gpio_rdata),
        .i_pwm_rdata    (pwm_rdata),
        .o_gpio_wr      (gpio_wr),
        .o_pwm_wr       (pwm_wr),
        .o_rdata        (rdata)
    );

    read_data_hold i_hold (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_rdata              (rdata),
        .i_data_read_n        (i_data_read_n),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_complete (i_data_read_complete),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready)
    );

    gpio_ctrl i_gpio (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_wr           (gpio_wr),
        .i_offset       (i_addr[5:0]),
        .i_wdata        (i_data[7:0]),
        .i_ui_in        (i_ui_in),
        .o_rdata        (gpio_rdata),
        .o_gpio_out     (gpio_out),
        .o_func_sel     (func_sel),
        .o_audio_select (o_audio_select)
    );

    pin_func_mux i_pin_mux (
        .i_func_sel (func_sel),
        .i_gpio_out (gpio_out),
        .i_pwm_pins (pwm_pins),
        .o_uo_out   (o_uo_out)
    );

    pwm_byte i_pwm (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_wr     (pwm_wr),
        .i_offset (i_addr[3:0]),
        .i_wdata  (i_data[7:0]),
        .o_rdata  (pwm_rdata),
        .o_pins   (pwm_pins)
    );

    assign o_audio = pwm_pins[`PERIPH_PIN_W-1];  // PWM level on the top pin feeds audio

endmodule

// File: test/tb_periph_hub.sv
/*
 * Testbench for the peripheral hub: bus tasks, handshake properties,
 * GPIO, read timing, pin select and PWM checks
 */

`include "periph_cfg.svh"

module tb_periph_hub;

    localparam int TIMEOUT = 20;                // Cycles allowed for one handshake
    localparam int GPIO    = `PERIPH_GPIO_SLOT;
    localparam int PWM     = `PERIPH_PWM_SLOT;
    localparam int SEL_OFS = 'h20;              // First pin function select

    logic                      clk;
    logic                      rst_n;
    logic [`PERIPH_PIN_W-1:0]  i_ui_in;
    logic [`PERIPH_ADDR_W-1:0] i_addr;
    logic [`PERIPH_DATA_W-1:0] i_data;
    periph_pkg::access_t       i_data_write_n;
    periph_pkg::access_t       i_data_read_n;
    logic                      i_data_read_complete;
    logic [`PERIPH_DATA_W-1:0] o_data_out;
    logic                      o_data_ready;
    logic [`PERIPH_PIN_W-1:0]  o_uo_out;
    logic                      o_audio;
    logic                      o_audio_select;

    int checks;
    int errors;

    logic                      rd_req;
    logic                      wr_req;
    logic                      rd_req_q;         // Request one edge back
    logic                      rd_req_qq;        // Request two edges back
    logic                      done_q;
    logic [`PERIPH_DATA_W-1:0] data_out_q;

    periph_hub i_dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (i_ui_in),
        .i_addr               (i_addr),
        .i_data               (i_data),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_read_complete (i_data_read_complete),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready),
        .o_uo_out             (o_uo_out),
        .o_audio              (o_audio),
        .o_audio_select       (o_audio_select)
    );

    always #5 clk = ~clk;

    assign rd_req = i_data_read_n != periph_pkg::ACC_NONE;
    assign wr_req = i_data_write_n != periph_pkg::ACC_NONE;

    always @(posedge clk) begin
        rd_req_q   <= rd_req;
        rd_req_qq  <= rd_req_q;
        done_q     <= i_data_read_complete;
        data_out_q <= o_data_out;
    end

    // Writes are acknowledged in their own cycle
    write_ready_a: assert property (@(posedge clk) disable iff (!rst_n) wr_req |-> o_data_ready)
    else begin
        errors++;
        $display("Fail o_data_ready: got 0x0, expected 0x1 during a write");
    end

    // Without a write, ready is the read request of the previous cycle
    read_ready_a: assert property (@(posedge clk) disable iff (!rst_n)
        !wr_req |-> (o_data_ready == rd_req_q))
    else begin
        errors++;
        $display("Fail o_data_ready: got 0x%h, expected 0x%h",
                 $sampled(o_data_ready), $sampled(rd_req_q));
    end

    // Read data stays put while the request is held and one cycle past read complete
    data_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        ((rd_req_q && rd_req_qq) || done_q) |-> (o_data_out == data_out_q))
    else begin
        errors++;
        $display("Fail o_data_out: got 0x%h, expected 0x%h",
                 $sampled(o_data_out), $sampled(data_out_q));
    end

    function automatic logic [`PERIPH_ADDR_W-1:0] user_addr(input int slot, input int ofs);
        return {1'b0, 4'(slot), 6'(ofs)};
    endfunction

    function automatic logic [`PERIPH_ADDR_W-1:0] simple_addr(input int slot, input int ofs);
        return {1'b1, 2'b00, 4'(slot), 4'(ofs)};
    endfunction

    // Pin function code as written to a select register
    function automatic logic [7:0] func_code(input bit simple, input int slot);
        return {3'b000, simple, 4'(slot)};
    endfunction

    task automatic end_run;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        errors++;
        $display("Timed out waiting for o_data_ready on a %s", what);
        end_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic bus_write(input logic [`PERIPH_ADDR_W-1:0] addr, input logic [7:0] data);
        int n;
        @(negedge clk);
        i_addr         = addr;
        i_data         = {24'($urandom), data};  // Upper bytes are ignored
        i_data_write_n = periph_pkg::ACC_BYTE;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!o_data_ready && n < TIMEOUT);
        if (!o_data_ready) begin
            abort_on_timeout("write");
        end else begin
            @(negedge clk);
            i_data_write_n = periph_pkg::ACC_NONE;
        end
    endtask

    // Holds the request for a few extra cycles and may move the input pins
    task automatic bus_read(input logic [`PERIPH_ADDR_W-1:0] addr, input bit vary_pins,
                            output logic [31:0] data);
        int n;
        int extra;
        @(negedge clk);
        i_addr        = addr;
        i_data_read_n = periph_pkg::ACC_WORD;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!o_data_ready && n < TIMEOUT);
        if (!o_data_ready) begin
            abort_on_timeout("read");
        end else begin
            data  = o_data_out;
            extra = 1 + int'($urandom_range(2));
            repeat (extra) begin
                if (vary_pins) begin
                    i_ui_in = i_ui_in ^ 8'($urandom_range(255, 1));
                end
                @(negedge clk);
            end
            i_data_read_n        = periph_pkg::ACC_NONE;
            i_data_read_complete = 1'b1;
            @(negedge clk);
            i_data_read_complete = 1'b0;
        end
    endtask

    initial begin
        logic [7:0]  val;
        logic [7:0]  duty;
        logic [31:0] rd;
        int          high;
        void'($urandom(29));
        checks               = 0;
        errors               = 0;
        clk                  = 1'b0;
        rst_n                = 1'b0;
        i_ui_in              = '0;
        i_addr               = '0;
        i_data               = '0;
        i_data_write_n       = periph_pkg::ACC_NONE;
        i_data_read_n        = periph_pkg::ACC_NONE;
        i_data_read_complete = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Reset state has every pin on GPIO
        check_value("o_uo_out", 32'(o_uo_out), 32'h0);
        check_value("o_audio_select", 32'(o_audio_select), 32'h0);
        check_value("o_data_ready", 32'(o_data_ready), 32'h0);
        for (int p = 0; p < `PERIPH_PIN_W; p++) begin
            bus_read(user_addr(GPIO, SEL_OFS + 4 * p), 1'b0, rd);
            check_value("o_data_out", rd, 32'(func_code(1'b0, GPIO)));
        end

        // GPIO output register and input readback
        val = 8'($urandom);
        bus_write(user_addr(GPIO, `GPIO_OUT_OFS), val);
        check_value("o_uo_out", 32'(o_uo_out), 32'(val));
        bus_read(user_addr(GPIO, `GPIO_OUT_OFS), 1'b0, rd);
        check_value("o_data_out", rd, 32'(val));
        i_ui_in = 8'($urandom);
        val     = i_ui_in;
        bus_read(user_addr(GPIO, `GPIO_IN_OFS), 1'b1, rd);
        check_value("o_data_out", rd, 32'(val));

        // Empty slots answer at once with zero
        bus_write(user_addr(12, 0), 8'hA5);
        bus_read(user_addr(9, 4), 1'b0, rd);
        check_value("o_data_out", rd, 32'h0);
        bus_read(simple_addr(2, 0), 1'b0, rd);
        check_value("o_data_out", rd, 32'h0);

        // Pin 3 on the PWM at duty 0 and pin 6 on an empty slot
        bus_write(user_addr(GPIO, `GPIO_OUT_OFS), 8'hFF);
        bus_write(user_addr(GPIO, SEL_OFS + 4 * 3), func_code(1'b1, PWM));
        check_value("o_uo_out", 32'(o_uo_out), 32'hF7);
        bus_write(user_addr(GPIO, SEL_OFS + 4 * 6), func_code(1'b0, 7));
        check_value("o_uo_out", 32'(o_uo_out), 32'hB7);
        bus_write(user_addr(GPIO, SEL_OFS + 4 * 3), func_code(1'b0, GPIO));
        bus_write(user_addr(GPIO, SEL_OFS + 4 * 6), func_code(1'b0, GPIO));
        check_value("o_uo_out", 32'(o_uo_out), 32'hFF);

        // PWM duty over a full 256-cycle window
        repeat (2) begin
            duty = 8'($urandom_range(255, 1));
            bus_write(simple_addr(PWM, `PWM_DUTY_OFS), duty);
            bus_read(simple_addr(PWM, `PWM_DUTY_OFS), 1'b0, rd);
            check_value("o_data_out", rd, 32'(duty));
            high = 0;
            repeat (256) begin
                @(negedge clk);
                if (o_audio) begin
                    high++;
                end
            end
            check_value("o_audio high count", high, 32'(duty));
        end
        bus_read(simple_addr(PWM, 4), 1'b0, rd);
        check_value("o_data_out", rd, 32'h0);

        // Bit 2 of the audio select routes the PWM out
        bus_write(user_addr(GPIO, `GPIO_AUDIO_OFS), 8'h04);
        check_value("o_audio_select", 32'(o_audio_select), 32'h1);
        bus_read(user_addr(GPIO, `GPIO_AUDIO_OFS), 1'b0, rd);
        check_value("o_data_out", rd, 32'h4);

        end_run();
    end

endmodule

// File: files.f
+incdir+src
src/periph_pkg.sv
src/periph_decode.sv
src/read_data_hold.sv
src/gpio_ctrl.sv
src/pin_func_mux.sv
src/pwm_byte.sv
src/periph_hub.sv
test/tb_periph_hub.sv

// File: run.sh
#!/bin/sh
# Build and run the peripheral hub testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_periph_hub \
    -f files.f --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_periph_hub)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The run passes only if the testbench printed its pass line
if printf '%s\n' "$output" | grep -qx "all tests passed"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1
